/* logic/uarch_pkg.sv */
//----------------------------------------------------------------------------
// Shared micro-op encoding and widths for the RV32 execute stage.
// Only ALU, branch and jump micro-ops are defined. No mul/div, no memory.
//----------------------------------------------------------------------------
package uarch_pkg;

  // In-order sequence number and physical register widths
  localparam int seq_num_bits   = 6;
  localparam int phys_addr_bits = 6;

  // Micro-op encoding
  typedef enum logic [4:0] {
    OP_ADD  = 5'd0,
    OP_SUB  = 5'd1,
    OP_AND  = 5'd2,
    OP_OR   = 5'd3,
    OP_XOR  = 5'd4,
    OP_SLT  = 5'd5,
    OP_SLLI = 5'd6,
    OP_SRLI = 5'd7,
    OP_BEQ  = 5'd8,
    OP_BNE  = 5'd9,
    OP_BLT  = 5'd10,
    OP_BGE  = 5'd11,
    OP_BLTU = 5'd12,
    OP_BGEU = 5'd13,
    OP_JAL  = 5'd14,
    OP_JALR = 5'd15
  } rv_uop;

  // Third operand word, read as offset or as shift amount
  typedef union packed {
    logic signed [31:0] branch_imm;
    struct packed {
      logic [26:0] rsvd;
      logic [4:0]  shamt;
    } alu_view;
  } op3_u;

  // True for ops executed by the control-flow unit
  function automatic logic is_ctrl_flow(rv_uop uop);
    return uop inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL, OP_JALR};
  endfunction

endpackage

/* logic/dx_intf.sv */
//----------------------------------------------------------------------------
// Issue to execute channel, one micro-op with operands already read.
// Valid/ready handshake. Payload holds steady until val & rdy.
//----------------------------------------------------------------------------
interface dx_intf;
  import uarch_pkg::*;

  logic                      val;
  logic                      rdy;
  logic [31:0]               pc;
  logic [seq_num_bits-1:0]   seq_num;
  logic [31:0]               op1;
  logic [31:0]               op2;
  op3_u                      op3;
  logic [4:0]                waddr;
  rv_uop                     uop;
  logic [phys_addr_bits-1:0] preg;
  logic [phys_addr_bits-1:0] ppreg;

  // Issue side
  modport d_intf (output val, pc, seq_num, op1, op2, op3, waddr, uop, preg, ppreg,
                  input rdy);

  // Execute side
  modport x_intf (input val, pc, seq_num, op1, op2, op3, waddr, uop, preg, ppreg,
                  output rdy);

endinterface

/* logic/xw_intf.sv */
//----------------------------------------------------------------------------
// Execute to writeback channel, one result per transfer.
//----------------------------------------------------------------------------
interface xw_intf;
  import uarch_pkg::*;

  logic                      val;
  logic                      rdy;
  logic [31:0]               pc;
  logic [seq_num_bits-1:0]   seq_num;
  logic [4:0]                waddr;
  logic [31:0]               wdata;
  logic                      wen;
  logic [phys_addr_bits-1:0] preg;
  logic [phys_addr_bits-1:0] ppreg;

  // Execute unit side
  modport x_intf (output val, pc, seq_num, waddr, wdata, wen, preg, ppreg,
                  input rdy);

  // Writeback side
  modport w_intf (input val, pc, seq_num, waddr, wdata, wen, preg, ppreg,
                  output rdy);

endinterface

/* logic/issue_router.sv */
//----------------------------------------------------------------------------
// Combinational steering of one micro-op to the CFU or the ALU unit.
// Payload goes to both units, only the chosen one sees val.
//----------------------------------------------------------------------------
module issue_router (
  input  logic                                  in_val,
  output logic                                  in_rdy,
  input  logic [31:0]                           in_pc,
  input  logic [uarch_pkg::seq_num_bits-1:0]    in_seq_num,
  input  logic [31:0]                           in_op1,
  input  logic [31:0]                           in_op2,
  input  uarch_pkg::op3_u                       in_op3,
  input  logic [4:0]                            in_waddr,
  input  uarch_pkg::rv_uop                      in_uop,
  input  logic [uarch_pkg::phys_addr_bits-1:0]  in_preg,
  input  logic [uarch_pkg::phys_addr_bits-1:0]  in_ppreg,
  dx_intf.d_intf                                cfu,
  dx_intf.d_intf                                alu
);
  import uarch_pkg::*;

  logic to_cfu;

  // Class decode
  assign to_cfu  = is_ctrl_flow(in_uop);

  // Only the selected unit sees a valid op
  assign cfu.val = in_val & to_cfu;
  assign alu.val = in_val & ~to_cfu;
  assign in_rdy  = to_cfu ? cfu.rdy : alu.rdy;

  // Broadcast payload
  assign cfu.pc      = in_pc;
  assign cfu.seq_num = in_seq_num;
  assign cfu.op1     = in_op1;
  assign cfu.op2     = in_op2;
  assign cfu.op3     = in_op3;
  assign cfu.waddr   = in_waddr;
  assign cfu.uop     = in_uop;
  assign cfu.preg    = in_preg;
  assign cfu.ppreg   = in_ppreg;

  assign alu.pc      = in_pc;
  assign alu.seq_num = in_seq_num;
  assign alu.op1     = in_op1;
  assign alu.op2     = in_op2;
  assign alu.op3     = in_op3;
  assign alu.waddr   = in_waddr;
  assign alu.uop     = in_uop;
  assign alu.preg    = in_preg;
  assign alu.ppreg   = in_ppreg;

endmodule

/* logic/control_flow_unit.sv */
//----------------------------------------------------------------------------
// Branch and jump execute unit with a one-entry register.
// Jump targets are predicted in the front end, so jumps never squash.
// Squash is a one-cycle pulse with no acknowledge.
//----------------------------------------------------------------------------
module control_flow_unit (
  input  logic                               clk,
  input  logic                               rst,
  dx_intf.x_intf                             d,
  xw_intf.x_intf                             w,
  output logic                               squash_val,
  output logic [31:0]                        squash_target,
  output logic [uarch_pkg::seq_num_bits-1:0] squash_seq_num
);
  import uarch_pkg::*;

  logic                      d_xfer;
  logic                      w_xfer;
  logic                      val_q;
  logic [31:0]               pc_q;
  logic [seq_num_bits-1:0]   seq_num_q;
  logic [31:0]               op1_q;
  logic [31:0]               op2_q;
  logic [31:0]               imm_q;
  logic [4:0]                waddr_q;
  rv_uop                     uop_q;
  logic [phys_addr_bits-1:0] preg_q;
  logic [phys_addr_bits-1:0] ppreg_q;
  logic                      squash_sent;
  logic                      taken;

  assign d_xfer = d.val & d.rdy;
  assign w_xfer = w.val & w.rdy;

  //--------------------------------------------------------------------------
  // Holding register
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (d_xfer) begin
      val_q <= 1'b1;
    end else if (w_xfer) begin
      val_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      pc_q      <= d.pc;
      seq_num_q <= d.seq_num;
      op1_q     <= d.op1;
      op2_q     <= d.op2;
      imm_q     <= d.op3.branch_imm;
      waddr_q   <= d.waddr;
      uop_q     <= d.uop;
      preg_q    <= d.preg;
      ppreg_q   <= d.ppreg;
    end
  end

  // Free when empty or draining this cycle
  assign d.rdy = ~val_q | w_xfer;

  //--------------------------------------------------------------------------
  // Branch resolution and squash
  //--------------------------------------------------------------------------

  always_comb begin
    case (uop_q)
      OP_BEQ:  taken = (op1_q == op2_q);
      OP_BNE:  taken = (op1_q != op2_q);
      OP_BLT:  taken = ($signed(op1_q) < $signed(op2_q));
      OP_BGE:  taken = ($signed(op1_q) >= $signed(op2_q));
      OP_BLTU: taken = (op1_q < op2_q);
      OP_BGEU: taken = (op1_q >= op2_q);
      default: taken = 1'b0;
    endcase
  end

  // Cleared by each accept, set one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      squash_sent <= 1'b1;
    end else begin
      squash_sent <= ~d_xfer;
    end
  end

  assign squash_val     = val_q & taken & ~squash_sent;
  assign squash_target  = pc_q + imm_q;
  assign squash_seq_num = seq_num_q;

  //--------------------------------------------------------------------------
  // Result
  //--------------------------------------------------------------------------

  // Link write for jumps only
  assign w.wen     = (uop_q == OP_JAL) | (uop_q == OP_JALR);
  assign w.wdata   = pc_q + 32'd4;
  assign w.val     = val_q;
  assign w.pc      = pc_q;
  assign w.seq_num = seq_num_q;
  assign w.waddr   = waddr_q;
  assign w.preg    = preg_q;
  assign w.ppreg   = ppreg_q;

endmodule

/* logic/alu_unit.sv */
//----------------------------------------------------------------------------
// Integer ALU execute unit with a one-entry register.
// Result is computed from the held operands. Shifts use op3 shamt.
//----------------------------------------------------------------------------
module alu_unit (
  input  logic   clk,
  input  logic   rst,
  dx_intf.x_intf d,
  xw_intf.x_intf w
);
  import uarch_pkg::*;

  logic                      d_xfer;
  logic                      w_xfer;
  logic                      val_q;
  logic [31:0]               pc_q;
  logic [seq_num_bits-1:0]   seq_num_q;
  logic [31:0]               op1_q;
  logic [31:0]               op2_q;
  logic [4:0]                shamt_q;
  logic [4:0]                waddr_q;
  rv_uop                     uop_q;
  logic [phys_addr_bits-1:0] preg_q;
  logic [phys_addr_bits-1:0] ppreg_q;

  assign d_xfer = d.val & d.rdy;
  assign w_xfer = w.val & w.rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (d_xfer) begin
      val_q <= 1'b1;
    end else if (w_xfer) begin
      val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (d_xfer) begin
      pc_q      <= d.pc;
      seq_num_q <= d.seq_num;
      op1_q     <= d.op1;
      op2_q     <= d.op2;
      shamt_q   <= d.op3.alu_view.shamt;
      waddr_q   <= d.waddr;
      uop_q     <= d.uop;
      preg_q    <= d.preg;
      ppreg_q   <= d.ppreg;
    end
  end

  assign d.rdy = ~val_q | w_xfer;

  // Result select
  always_comb begin
    case (uop_q)
      OP_ADD:  w.wdata = op1_q + op2_q;
      OP_SUB:  w.wdata = op1_q - op2_q;
      OP_AND:  w.wdata = op1_q & op2_q;
      OP_OR:   w.wdata = op1_q | op2_q;
      OP_XOR:  w.wdata = op1_q ^ op2_q;
      OP_SLT:  w.wdata = {31'd0, $signed(op1_q) < $signed(op2_q)};
      OP_SLLI: w.wdata = op1_q << shamt_q;
      OP_SRLI: w.wdata = op1_q >> shamt_q;
      default: w.wdata = 32'd0;
    endcase
  end

  // Every ALU op writes its destination
  assign w.wen     = 1'b1;
  assign w.val     = val_q;
  assign w.pc      = pc_q;
  assign w.seq_num = seq_num_q;
  assign w.waddr   = waddr_q;
  assign w.preg    = preg_q;
  assign w.ppreg   = ppreg_q;

endmodule

/* logic/writeback_arbiter.sv */
//----------------------------------------------------------------------------
// Round-robin merge of CFU and ALU results onto one writeback port.
// Grant is combinational. Only the granted unit sees wb_rdy.
//----------------------------------------------------------------------------
module writeback_arbiter (
  input  logic                                 clk,
  input  logic                                 rst,
  xw_intf.w_intf                               cfu,
  xw_intf.w_intf                               alu,
  output logic                                 wb_val,
  input  logic                                 wb_rdy,
  output logic [31:0]                          wb_pc,
  output logic [uarch_pkg::seq_num_bits-1:0]   wb_seq_num,
  output logic [4:0]                           wb_waddr,
  output logic [31:0]                          wb_wdata,
  output logic                                 wb_wen,
  output logic [uarch_pkg::phys_addr_bits-1:0] wb_preg,
  output logic [uarch_pkg::phys_addr_bits-1:0] wb_ppreg
);

  logic last_alu;
  logic grant_cfu;
  logic grant_alu;

  // On a tie the unit not granted last wins
  assign grant_cfu = cfu.val & (~alu.val | last_alu);
  assign grant_alu = alu.val & ~grant_cfu;

  // Pointer moves on each writeback transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      last_alu <= 1'b1;
    end else if (wb_val & wb_rdy) begin
      last_alu <= grant_alu;
    end
  end

  assign cfu.rdy = wb_rdy & grant_cfu;
  assign alu.rdy = wb_rdy & grant_alu;

  // Payload mux
  assign wb_val     = grant_cfu | grant_alu;
  assign wb_pc      = grant_alu ? alu.pc      : cfu.pc;
  assign wb_seq_num = grant_alu ? alu.seq_num : cfu.seq_num;
  assign wb_waddr   = grant_alu ? alu.waddr   : cfu.waddr;
  assign wb_wdata   = grant_alu ? alu.wdata   : cfu.wdata;
  assign wb_wen     = grant_alu ? alu.wen     : cfu.wen;
  assign wb_preg    = grant_alu ? alu.preg    : cfu.preg;
  assign wb_ppreg   = grant_alu ? alu.ppreg   : cfu.ppreg;

endmodule

/* logic/execute_top.sv */
//----------------------------------------------------------------------------
// Execute stage top. Up to two ops in flight, one per unit.
// Order is kept within a unit but not across the two units.
//----------------------------------------------------------------------------
module execute_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 in_val,
  output logic                                 in_rdy,
  input  logic [31:0]                          in_pc,
  input  logic [uarch_pkg::seq_num_bits-1:0]   in_seq_num,
  input  logic [31:0]                          in_op1,
  input  logic [31:0]                          in_op2,
  input  uarch_pkg::op3_u                      in_op3,
  input  logic [4:0]                           in_waddr,
  input  uarch_pkg::rv_uop                     in_uop,
  input  logic [uarch_pkg::phys_addr_bits-1:0] in_preg,
  input  logic [uarch_pkg::phys_addr_bits-1:0] in_ppreg,
  output logic                                 wb_val,
  input  logic                                 wb_rdy,
  output logic [31:0]                          wb_pc,
  output logic [uarch_pkg::seq_num_bits-1:0]   wb_seq_num,
  output logic [4:0]                           wb_waddr,
  output logic [31:0]                          wb_wdata,
  output logic                                 wb_wen,
  output logic [uarch_pkg::phys_addr_bits-1:0] wb_preg,
  output logic [uarch_pkg::phys_addr_bits-1:0] wb_ppreg,
  output logic                                 squash_val,
  output logic [31:0]                          squash_target,
  output logic [uarch_pkg::seq_num_bits-1:0]   squash_seq_num
);

  // Issue to unit channels
  dx_intf cfu_dx ();
  dx_intf alu_dx ();

  // Unit to writeback channels
  xw_intf cfu_xw ();
  xw_intf alu_xw ();

  issue_router router (
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_pc      (in_pc),
    .in_seq_num (in_seq_num),
    .in_op1     (in_op1),
    .in_op2     (in_op2),
    .in_op3     (in_op3),
    .in_waddr   (in_waddr),
    .in_uop     (in_uop),
    .in_preg    (in_preg),
    .in_ppreg   (in_ppreg),
    .cfu        (cfu_dx),
    .alu        (alu_dx)
  );

  control_flow_unit cfu (
    .clk            (clk),
    .rst            (rst),
    .d              (cfu_dx),
    .w              (cfu_xw),
    .squash_val     (squash_val),
    .squash_target  (squash_target),
    .squash_seq_num (squash_seq_num)
  );

  alu_unit alu (
    .clk (clk),
    .rst (rst),
    .d   (alu_dx),
    .w   (alu_xw)
  );

  writeback_arbiter arb (
    .clk        (clk),
    .rst        (rst),
    .cfu        (cfu_xw),
    .alu        (alu_xw),
    .wb_val     (wb_val),
    .wb_rdy     (wb_rdy),
    .wb_pc      (wb_pc),
    .wb_seq_num (wb_seq_num),
    .wb_waddr   (wb_waddr),
    .wb_wdata   (wb_wdata),
    .wb_wen     (wb_wen),
    .wb_preg    (wb_preg),
    .wb_ppreg   (wb_ppreg)
  );

endmodule

/* tests/execute_checker.sv */
//----------------------------------------------------------------------------
// Watches the execute stage ports, models each accepted op, and compares
// every writeback and squash with the model. Results are matched to their
// class queue by sequence number, so at most two ops may be in flight.
//----------------------------------------------------------------------------
module execute_checker (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 in_val,
  input  logic                                 in_rdy,
  input  logic [31:0]                          in_pc,
  input  logic [uarch_pkg::seq_num_bits-1:0]   in_seq_num,
  input  logic [31:0]                          in_op1,
  input  logic [31:0]                          in_op2,
  input  uarch_pkg::op3_u                      in_op3,
  input  logic [4:0]                           in_waddr,
  input  uarch_pkg::rv_uop                     in_uop,
  input  logic [uarch_pkg::phys_addr_bits-1:0] in_preg,
  input  logic [uarch_pkg::phys_addr_bits-1:0] in_ppreg,
  input  logic                                 wb_val,
  input  logic                                 wb_rdy,
  input  logic [31:0]                          wb_pc,
  input  logic [uarch_pkg::seq_num_bits-1:0]   wb_seq_num,
  input  logic [4:0]                           wb_waddr,
  input  logic [31:0]                          wb_wdata,
  input  logic                                 wb_wen,
  input  logic [uarch_pkg::phys_addr_bits-1:0] wb_preg,
  input  logic [uarch_pkg::phys_addr_bits-1:0] wb_ppreg,
  input  logic                                 squash_val,
  input  logic [31:0]                          squash_target,
  input  logic [uarch_pkg::seq_num_bits-1:0]   squash_seq_num,
  output int                                   pending
);
  timeunit 1ns;
  timeprecision 100ps;
  import uarch_pkg::*;

  // One expected writeback
  typedef struct packed {
    logic [31:0]               pc;
    logic [seq_num_bits-1:0]   seq;
    logic [4:0]                waddr;
    logic [31:0]               wdata;
    logic                      wen;
    logic [phys_addr_bits-1:0] preg;
    logic [phys_addr_bits-1:0] ppreg;
    rv_uop                     uop;
  } result_t;

  result_t                 cfu_q[$];
  result_t                 alu_q[$];
  logic                    exp_sq;
  logic [31:0]             exp_sq_target;
  logic [seq_num_bits-1:0] exp_sq_seq;
  logic                    rst_prev;
  int                      checks[1:6];
  int                      errs[1:6];

  initial begin
    exp_sq   = 1'b0;
    rst_prev = 1'b0;
    pending  = 0;
    foreach (checks[i]) begin
      checks[i] = 0;
      errs[i]   = 0;
    end
  end

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------

  // Branches and jumps sit at the top of the encoding
  function automatic logic goes_to_cfu(rv_uop uop);
    return uop >= OP_BEQ;
  endfunction

  function automatic logic [31:0] alu_result(rv_uop uop, logic [31:0] a, logic [31:0] b,
                                             logic [31:0] c);
    case (uop)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      // Shift amount is the low 5 bits of op3
      OP_SLLI: return a << c[4:0];
      OP_SRLI: return a >> c[4:0];
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic branch_taken(rv_uop uop, logic [31:0] a, logic [31:0] b);
    case (uop)
      OP_BEQ:  return a == b;
      OP_BNE:  return a != b;
      OP_BLT:  return $signed(a) < $signed(b);
      OP_BGE:  return $signed(a) >= $signed(b);
      OP_BLTU: return a < b;
      OP_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  //--------------------------------------------------------------------------
  // Comparison
  //--------------------------------------------------------------------------

  task automatic flag(int test, string msg);
    errs[test]++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic compare_result(result_t exp);
    int test;
    // 2 ALU, 3 branch, 4 jump
    test = (exp.uop inside {OP_JAL, OP_JALR}) ? 4 : (goes_to_cfu(exp.uop) ? 3 : 2);
    checks[test]++;
    checks[5]++;
    if (wb_wen !== exp.wen)
      flag(test, $sformatf("seq %0d %s wen %b, expected %b",
                           exp.seq, exp.uop.name(), wb_wen, exp.wen));
    if (exp.wen && wb_wdata !== exp.wdata)
      flag(test, $sformatf("seq %0d %s wdata %h, expected %h",
                           exp.seq, exp.uop.name(), wb_wdata, exp.wdata));
    if (wb_pc !== exp.pc || wb_waddr !== exp.waddr || wb_preg !== exp.preg ||
        wb_ppreg !== exp.ppreg)
      flag(5, $sformatf("seq %0d pass-through pc %h/%h waddr %0d/%0d preg %0d/%0d ppreg %0d/%0d",
                        exp.seq, wb_pc, exp.pc, wb_waddr, exp.waddr,
                        wb_preg, exp.preg, wb_ppreg, exp.ppreg));
  endtask

  //--------------------------------------------------------------------------
  // Per-edge monitor, values sampled before the edge updates
  //--------------------------------------------------------------------------

  always @(posedge clk) begin : watch
    result_t nxt;
    rst_prev <= rst;
    if (rst) begin
      exp_sq = 1'b0;
    end else begin
      // First cycle out of reset
      if (rst_prev) begin
        checks[1]++;
        if (wb_val !== 1'b0 || squash_val !== 1'b0 || in_rdy !== 1'b1)
          flag(1, $sformatf("after reset wb_val %b squash_val %b in_rdy %b",
                            wb_val, squash_val, in_rdy));
      end
      // Squash due the cycle after the accepting edge
      if (exp_sq || squash_val) checks[3]++;
      if (squash_val !== exp_sq)
        flag(3, $sformatf("squash_val %b, expected %b", squash_val, exp_sq));
      else if (exp_sq && (squash_target !== exp_sq_target || squash_seq_num !== exp_sq_seq))
        flag(3, $sformatf("squash target %h seq %0d, expected %h seq %0d",
                          squash_target, squash_seq_num, exp_sq_target, exp_sq_seq));
      exp_sq = 1'b0;
      // Writeback transfer, matched by seq_num against the queue heads
      if (wb_val && wb_rdy) begin
        if (cfu_q.size() > 0 && cfu_q[0].seq == wb_seq_num) begin
          compare_result(cfu_q.pop_front());
        end else if (alu_q.size() > 0 && alu_q[0].seq == wb_seq_num) begin
          compare_result(alu_q.pop_front());
        end else begin
          checks[5]++;
          flag(5, $sformatf("unexpected writeback seq %0d", wb_seq_num));
        end
      end
      // Accepted op
      if (in_val && in_rdy) begin
        nxt.pc    = in_pc;
        nxt.seq   = in_seq_num;
        nxt.waddr = in_waddr;
        nxt.preg  = in_preg;
        nxt.ppreg = in_ppreg;
        nxt.uop   = in_uop;
        if (goes_to_cfu(in_uop)) begin
          // Link value for jumps only
          nxt.wen   = in_uop inside {OP_JAL, OP_JALR};
          nxt.wdata = in_pc + 32'd4;
          cfu_q.push_back(nxt);
          if (branch_taken(in_uop, in_op1, in_op2)) begin
            exp_sq        = 1'b1;
            exp_sq_target = in_pc + in_op3;
            exp_sq_seq    = in_seq_num;
          end
        end else begin
          nxt.wen   = 1'b1;
          nxt.wdata = alu_result(in_uop, in_op1, in_op2, in_op3);
          alu_q.push_back(nxt);
        end
      end
      pending <= cfu_q.size() + alu_q.size();
    end
  end

  //--------------------------------------------------------------------------
  // End of run summary
  //--------------------------------------------------------------------------

  task automatic final_report(output int total_errs, output int total_checks);
    string names[1:6] = '{"reset state", "alu results", "branches and squash",
                          "jumps", "order and pass-through", "drain"};
    checks[6]++;
    if (cfu_q.size() > 0) begin
      errs[6]++;
      $display("%0d control-flow results were never written back, oldest seq %0d",
               cfu_q.size(), cfu_q[0].seq);
    end
    if (alu_q.size() > 0) begin
      errs[6]++;
      $display("%0d ALU results were never written back, oldest seq %0d",
               alu_q.size(), alu_q[0].seq);
    end
    total_errs   = 0;
    total_checks = 0;
    foreach (names[i]) begin
      $display("test %0d %-24s %0d checked, %0d errors", i, names[i], checks[i], errs[i]);
      total_errs   += errs[i];
      total_checks += checks[i];
    end
  endtask

endmodule

/* tests/execute_tb.sv */
//----------------------------------------------------------------------------
// Execute stage testbench. Random ops from a fixed seed under random
// writeback back-pressure. Comparison lives in the checker instance.
//----------------------------------------------------------------------------
module execute_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import uarch_pkg::*;

  localparam int num_ops       = 400;
  localparam int cycle_timeout = 200;

  logic                      clk;
  logic                      rst;
  logic                      in_val;
  logic                      in_rdy;
  logic [31:0]               in_pc;
  logic [seq_num_bits-1:0]   in_seq_num;
  logic [31:0]               in_op1;
  logic [31:0]               in_op2;
  op3_u                      in_op3;
  logic [4:0]                in_waddr;
  rv_uop                     in_uop;
  logic [phys_addr_bits-1:0] in_preg;
  logic [phys_addr_bits-1:0] in_ppreg;
  logic                      wb_val;
  logic                      wb_rdy;
  logic [31:0]               wb_pc;
  logic [seq_num_bits-1:0]   wb_seq_num;
  logic [4:0]                wb_waddr;
  logic [31:0]               wb_wdata;
  logic                      wb_wen;
  logic [phys_addr_bits-1:0] wb_preg;
  logic [phys_addr_bits-1:0] wb_ppreg;
  logic                      squash_val;
  logic [31:0]               squash_target;
  logic [seq_num_bits-1:0]   squash_seq_num;
  int                        pending;
  int                        seed;
  logic                      timed_out;

  execute_top uut (.*);

  execute_checker chk (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // One clock edge, with a fresh back-pressure draw (ready 3 cycles in 4)
  task automatic step_clock;
    @(posedge clk);
    wb_rdy <= ($random(seed) & 3) != 0;
  endtask

  // Drive one random op and hold it until the DUT takes it
  task automatic issue_op(input logic [seq_num_bits-1:0] seq);
    rv_uop       uop;
    logic [31:0] r;
    logic [31:0] a;
    int          waited;
    uop = rv_uop'($unsigned($random(seed)) % 16);
    r   = $random(seed);
    a   = $random(seed);
    in_val     <= 1'b1;
    in_uop     <= uop;
    in_seq_num <= seq;
    in_pc      <= {r[31:2], 2'b00};
    in_op1     <= a;
    // Equal compare operands half the time for branches
    in_op2     <= (uop >= OP_BEQ && r[0]) ? a : $random(seed);
    in_waddr   <= $random(seed);
    in_preg    <= $random(seed);
    in_ppreg   <= $random(seed);
    // Small even offsets for branches, full random word for the ALU
    if (uop >= OP_BEQ)
      in_op3 <= {{19{r[12]}}, r[12:1], 1'b0};
    else
      in_op3 <= $random(seed);
    waited = 0;
    do begin
      step_clock();
      waited++;
    end while (!in_rdy && waited < cycle_timeout);
    if (!in_rdy) begin
      timed_out = 1'b1;
      $display("in_rdy stayed low for %0d cycles at seq %0d", cycle_timeout, seq);
    end
    in_val <= 1'b0;
  endtask

  initial begin : stimulus
    int                      waited;
    int                      error_total;
    int                      check_total;
    logic [seq_num_bits-1:0] seq;
    seed       = 32'hb514;
    timed_out  = 1'b0;
    rst        = 1'b1;
    in_val     = 1'b0;
    in_pc      = '0;
    in_seq_num = '0;
    in_op1     = '0;
    in_op2     = '0;
    in_op3     = '0;
    in_waddr   = '0;
    in_uop     = OP_ADD;
    in_preg    = '0;
    in_ppreg   = '0;
    wb_rdy     = 1'b0;
    seq        = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    // Checker looks at the reset state here
    step_clock();
    step_clock();

    for (int i = 0; i < num_ops && !timed_out; i++) begin
      // Occasional idle cycle
      if (($random(seed) & 7) == 0) step_clock();
      issue_op(seq);
      seq++;
    end

    // Wait for every result to come out
    waited = 0;
    do begin
      step_clock();
      waited++;
    end while (pending != 0 && waited < cycle_timeout);
    if (pending != 0)
      $display("writeback did not drain within %0d cycles", cycle_timeout);
    // Checker is done with the last edge by now
    @(negedge clk);

    chk.final_report(error_total, check_total);
    $display("%0d checks, %0d errors", check_total, error_total);
    if (error_total == 0 && !timed_out)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* sim.f */
logic/uarch_pkg.sv
logic/dx_intf.sv
logic/xw_intf.sv
logic/issue_router.sv
logic/control_flow_unit.sv
logic/alu_unit.sv
logic/writeback_arbiter.sv
logic/execute_top.sv
tests/execute_checker.sv
tests/execute_tb.sv

/* Bender.yml */
package:
  name: execute_stage

sources:
  - logic/uarch_pkg.sv
  - logic/dx_intf.sv
  - logic/xw_intf.sv
  - logic/issue_router.sv
  - logic/control_flow_unit.sv
  - logic/alu_unit.sv
  - logic/writeback_arbiter.sv
  - logic/execute_top.sv
  - target: test
    files:
      - tests/execute_checker.sv
      - tests/execute_tb.sv
